/* Makefile */
VERILATOR ?= verilator
TB_TOP    ?= scoreboard_tb
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing --assert
PASS_MSG  ?= TESTBENCH PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TB_TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TB_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

/* list.f */
+incdir+.
manycore_addr_pkg.sv
vanilla_pipe_pkg.sv
tile_coord_cfg.sv
remote_addr_classifier.sv
scoreboard_tracker.sv
scoreboard_top.sv
scoreboard_assert.sv
scoreboard_tb.sv

/* manycore_addr_pkg.sv */
`include "scoreboard_defines.svh"

package manycore_addr_pkg;

  typedef logic [`SB_X_CORD_WIDTH-1:0] x_cord_t;
  typedef logic [`SB_Y_CORD_WIDTH-1:0] y_cord_t;
  typedef logic [`SB_GROUP_ADDR_WIDTH-1:0] group_addr_t;
  typedef logic [`SB_REMOTE_WIDTH-1:0] remote_t;

  // 32-bit address seen as a tile-group address
  typedef struct packed {
    remote_t     remote;
    y_cord_t     y_cord;
    x_cord_t     x_cord;
    group_addr_t addr;
  } tile_group_addr_s;

  // position of this tile relative to the group origin
  typedef struct packed {
    x_cord_t x;
    y_cord_t y;
  } tile_pos_s;

  // coordinate register select
  typedef logic [1:0] cfg_sel_t;

  localparam cfg_sel_t CFG_SEL_GLOBAL_X = 2'd0;
  localparam cfg_sel_t CFG_SEL_GLOBAL_Y = 2'd1;
  localparam cfg_sel_t CFG_SEL_ORIGIN_X = 2'd2;
  localparam cfg_sel_t CFG_SEL_ORIGIN_Y = 2'd3;

  typedef struct packed {
    logic     v;
    cfg_sel_t sel;
    x_cord_t  value;
  } coord_cfg_s;

endpackage

/* remote_addr_classifier.sv */
`include "scoreboard_defines.svh"

module remote_addr_classifier (
  input  vanilla_pipe_pkg::issue_s         issue_i,
  input  manycore_addr_pkg::tile_pos_s     tile_pos_i,
  output vanilla_pipe_pkg::remote_class_s  class_o
);
  import manycore_addr_pkg::*;
  import vanilla_pipe_pkg::*;

  data_t            eff_addr;
  tile_group_addr_s group_addr;
  logic             is_int_load;
  logic             is_fp_load;
  logic             in_dram;
  logic             in_global;
  logic             in_group;
  logic             is_my_tile;
  logic             in_ovf_window;

  assign is_int_load = issue_i.is_load & issue_i.write_rd;
  assign is_fp_load  = issue_i.is_load & issue_i.write_frd;

  // rs1 + sign-extended offset
  assign eff_addr = issue_i.rs1_val
                  + {{(`SB_DATA_WIDTH-`SB_IMM_WIDTH){issue_i.imm[`SB_IMM_WIDTH-1]}},
                     issue_i.imm};
  assign group_addr = eff_addr;

  // address space decode
  assign in_dram   = eff_addr[`SB_DATA_WIDTH-1];
  assign in_global = (eff_addr[`SB_DATA_WIDTH-1 -: 2] == 2'b01);
  assign in_group  = (group_addr.remote == 3'b001);

  assign is_my_tile = (group_addr.x_cord == tile_pos_i.x)
                    & (group_addr.y_cord == tile_pos_i.y);

  assign in_ovf_window = (group_addr.addr >= `SB_OVF_LO)
                       & (group_addr.addr <= `SB_OVF_HI);

  // integer side
  assign class_o.isb.idiv             = issue_i.is_idiv;
  assign class_o.isb.remote_dram_load = is_int_load & in_dram;
  assign class_o.isb.remote_dram_amo  = issue_i.is_amo & in_dram;

  // an amo anywhere in global space waits like a global load
  assign class_o.isb.remote_global_load = (is_int_load | issue_i.is_amo) & in_global;

  // amo to own tile still goes out through the network
  assign class_o.isb.remote_group_load = (is_int_load | issue_i.is_amo) & in_group
                                       & (~is_my_tile | issue_i.is_amo);
  assign class_o.isb.remote_group_amo  = issue_i.is_amo & in_group;

  assign class_o.isb.remote_dmem_overflow_load = is_int_load & in_group & is_my_tile
                                               & in_ovf_window;

  // float side
  assign class_o.fsb.fdiv_fsqrt         = issue_i.is_fdiv_fsqrt;
  assign class_o.fsb.remote_dram_load   = is_fp_load & in_dram;
  assign class_o.fsb.remote_global_load = is_fp_load & in_global;
  assign class_o.fsb.remote_group_load  = is_fp_load & in_group & ~is_my_tile;

  assign class_o.fsb.remote_dmem_overflow_load = is_fp_load & in_group & is_my_tile
                                               & in_ovf_window;

endmodule

/* scoreboard_assert.sv */
`include "scoreboard_defines.svh"

module scoreboard_assert (
  input logic                                          clk_i,
  input logic                                          reset_i,
  input logic                                          issue_v_i,
  input logic                                          stall_i,
  input logic                                          flush_i,
  input vanilla_pipe_pkg::reg_addr_t                   rd_i,
  input vanilla_pipe_pkg::isb_info_s [`SB_REG_ELS-1:0] int_sb_o,
  input vanilla_pipe_pkg::fsb_info_s [`SB_REG_ELS-1:0] float_sb_o
);
  timeunit 1ns;
  timeprecision 1ps;
  import vanilla_pipe_pkg::*;

  // number of assertion failures so far
  int fail_count = 0;

  a_reset_clears: assert property (@(posedge clk_i)
    reset_i |=> (int_sb_o == '0 && float_sb_o == '0))
    else begin
      fail_count++;
      $error("scoreboard not empty after reset");
    end

  // a gated issue must not raise anything
  a_gated_no_rise: assert property (@(posedge clk_i) disable iff (reset_i)
    (stall_i || flush_i) |=> ((int_sb_o & ~$past(int_sb_o)) == '0
                              && (float_sb_o & ~$past(float_sb_o)) == '0))
    else begin
      fail_count++;
      $error("scoreboard bit rose after a stalled or flushed cycle");
    end

  for (genvar i = 0; i < `SB_REG_ELS; i++) begin : g_reg
    a_rise_needs_issue: assert property (@(posedge clk_i) disable iff (reset_i)
      ((int_sb_o[i] & ~$past(int_sb_o[i])) != '0
       || (float_sb_o[i] & ~$past(float_sb_o[i])) != '0)
      |-> ($past(issue_v_i) && $past(rd_i) == reg_addr_t'(i)))
      else begin
        fail_count++;
        $error("entry %0d set without an issue to it", i);
      end
  end

endmodule

bind scoreboard_tracker scoreboard_assert u_sb_assert (
  .clk_i (clk_i), .reset_i (reset_i), .issue_v_i (issue_v_i), .stall_i (stall_i),
  .flush_i (flush_i), .rd_i (rd_i), .int_sb_o (int_sb_o), .float_sb_o (float_sb_o)
);

/* scoreboard_defines.svh */
`ifndef SCOREBOARD_DEFINES_SVH
`define SCOREBOARD_DEFINES_SVH

// datapath and register file sizes
`define SB_DATA_WIDTH 32
`define SB_REG_ELS 32
`define SB_REG_ADDR_WIDTH 5
`define SB_IMM_WIDTH 12

// tile coordinates
`define SB_X_CORD_WIDTH 6
`define SB_Y_CORD_WIDTH 5

// remote field sits above y, x and local addr in the group address map
`define SB_REMOTE_WIDTH 3
`define SB_GROUP_ADDR_WIDTH 18

// dmem overflow window inside the local address field
`define SB_OVF_LO 18'h00100
`define SB_OVF_HI 18'h0FCFF

`endif

/* scoreboard_tb.sv */
`include "scoreboard_defines.svh"

module scoreboard_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import manycore_addr_pkg::*;
  import vanilla_pipe_pkg::*;

  // {is_load, is_amo, is_idiv, is_fdiv_fsqrt, write_rd, write_frd}
  localparam logic [5:0] K_INT_LOAD = 6'b100010;
  localparam logic [5:0] K_FP_LOAD  = 6'b100001;
  localparam logic [5:0] K_AMO      = 6'b010010;
  localparam logic [5:0] K_IDIV     = 6'b001010;
  localparam logic [5:0] K_FDIV     = 6'b000101;
  // tests take roughly 330 cycles
  localparam int MAX_CYCLES = 2000;

  logic clk, reset, issue_v, stall, flush;
  coord_cfg_s cfg;
  issue_s issue;
  sb_clear_s int_clear, float_clear;
  isb_info_s [`SB_REG_ELS-1:0] int_sb;
  fsb_info_s [`SB_REG_ELS-1:0] float_sb;

  // reference state
  isb_info_s ref_int [`SB_REG_ELS];
  fsb_info_s ref_fp [`SB_REG_ELS];
  x_cord_t gx, ox;
  y_cord_t gy, oy;
  logic [31:0] rng;
  int cycle_count;

  scoreboard_top uut (
    .clk_i (clk), .reset_i (reset), .cfg_i (cfg), .issue_i (issue), .issue_v_i (issue_v),
    .stall_i (stall), .flush_i (flush), .int_clear_i (int_clear),
    .float_clear_i (float_clear), .int_sb_o (int_sb), .float_sb_o (float_sb)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= MAX_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
      $display("TESTBENCH FAILED");
      $fatal(1, "run aborted");
    end
  end

  function automatic logic [31:0] xorshift(logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic data_t grp(x_cord_t x, y_cord_t y, logic [17:0] a);
    return {3'b001, y, x, a};
  endfunction

  // expected flags straight from the address map rules
  function automatic remote_class_s classify(issue_s ins);
    tile_group_addr_s ga;
    logic ld_i, ld_f, dram, glob, in_grp, mine, ovf;
    remote_class_s c;
    ga = ins.rs1_val + 32'($signed(ins.imm));
    ld_i = ins.is_load && ins.write_rd;
    ld_f = ins.is_load && ins.write_frd;
    dram = ga.remote[2];
    glob = (ga.remote[2:1] == 2'b01);
    in_grp = (ga.remote == 3'b001);
    mine = (ga.x_cord == x_cord_t'(gx - ox)) && (ga.y_cord == y_cord_t'(gy - oy));
    ovf = (ga.addr >= `SB_OVF_LO) && (ga.addr <= `SB_OVF_HI);
    c = '0;
    c.isb.idiv = ins.is_idiv;
    c.isb.remote_dram_load = ld_i && dram;
    c.isb.remote_dram_amo = ins.is_amo && dram;
    c.isb.remote_global_load = (ld_i || ins.is_amo) && glob;
    c.isb.remote_group_load = in_grp && ((ld_i && !mine) || ins.is_amo);
    c.isb.remote_group_amo = ins.is_amo && in_grp;
    c.isb.remote_dmem_overflow_load = ld_i && in_grp && mine && ovf;
    c.fsb.fdiv_fsqrt = ins.is_fdiv_fsqrt;
    c.fsb.remote_dram_load = ld_f && dram;
    c.fsb.remote_global_load = ld_f && glob;
    c.fsb.remote_group_load = ld_f && in_grp && !mine;
    c.fsb.remote_dmem_overflow_load = ld_f && in_grp && mine && ovf;
    return c;
  endfunction

  task automatic check(string name, logic [31:0] got, logic [31:0] exp);
    if (got !== exp) begin
      $display("FAIL time=%0t %s got=%h expected=%h", $time, name, got, exp);
      $display("TESTBENCH FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic scan_assert_failures();
    if (uut.u_tracker.u_sb_assert.fail_count != 0) begin
      $display("a tracker assertion failed before time %0t", $time);
      $display("TESTBENCH FAILED");
      $fatal(1, "assertion failure");
    end
  endtask

  task automatic compare_all();
    for (int i = 0; i < `SB_REG_ELS; i++) begin
      check($sformatf("int_sb_o[%0d]", i), 32'(int_sb[i]), 32'(ref_int[i]));
      check($sformatf("float_sb_o[%0d]", i), 32'(float_sb[i]), 32'(ref_fp[i]));
    end
  endtask

  // update model, advance one clock, compare, then drop strobes
  task automatic tick();
    remote_class_s c;
    c = classify(issue);
    if (int_clear.v) ref_int[int_clear.id] = '0;
    if (float_clear.v) ref_fp[float_clear.id] = '0;
    if (issue_v && !stall && !flush) begin
      ref_int[issue.rd] = ref_int[issue.rd] | c.isb;
      ref_fp[issue.rd] = ref_fp[issue.rd] | c.fsb;
    end
    if (cfg.v) begin
      case (cfg.sel)
        2'd0: gx = cfg.value;
        2'd1: gy = cfg.value[`SB_Y_CORD_WIDTH-1:0];
        2'd2: ox = cfg.value;
        default: oy = cfg.value[`SB_Y_CORD_WIDTH-1:0];
      endcase
    end
    @(posedge clk);
    @(negedge clk);
    compare_all();
    scan_assert_failures();
    issue_v = 1'b0;
    stall = 1'b0;
    flush = 1'b0;
    cfg = '0;
    int_clear = '0;
    float_clear = '0;
  endtask

  task automatic send(logic [5:0] kind, reg_addr_t rd, data_t rs1, imm_t imm);
    issue = {kind, rd, rs1, imm};
    issue_v = 1'b1;
    tick();
  endtask

  task automatic write_cfg(logic [1:0] sel, x_cord_t value);
    cfg = {1'b1, sel, value};
    tick();
  endtask

  task automatic test_reset();
    for (int i = 0; i < `SB_REG_ELS; i++) begin
      check($sformatf("int_sb_o[%0d]", i), 32'(int_sb[i]), 32'd0);
      check($sformatf("float_sb_o[%0d]", i), 32'(float_sb[i]), 32'd0);
    end
    tick();
  endtask

  task automatic test_divides();
    send(K_IDIV, 5'd3, 32'h0, 12'h0);
    check("int_sb_o[3].idiv", 32'(int_sb[3].idiv), 32'd1);
    send(K_FDIV, 5'd7, 32'h0, 12'h0);
    check("float_sb_o[7].fdiv_fsqrt", 32'(float_sb[7].fdiv_fsqrt), 32'd1);
    int_clear = {1'b1, 5'd4};
    tick();
    check("int_sb_o[3].idiv", 32'(int_sb[3].idiv), 32'd1);
    int_clear = {1'b1, 5'd3};
    float_clear = {1'b1, 5'd7};
    tick();
    check("int_sb_o[3]", 32'(int_sb[3]), 32'd0);
    check("float_sb_o[7]", 32'(float_sb[7]), 32'd0);
  endtask

  task automatic test_dram_global();
    send(K_INT_LOAD, 5'd5, 32'h8000_0010, 12'h000);
    check("int_sb_o[5].remote_dram_load", 32'(int_sb[5].remote_dram_load), 32'd1);
    // 4 - 16 wraps into dram space
    send(K_INT_LOAD, 5'd6, 32'h0000_0004, 12'hff0);
    check("int_sb_o[6].remote_dram_load", 32'(int_sb[6].remote_dram_load), 32'd1);
    send(K_FP_LOAD, 5'd8, 32'h4000_1000, 12'h010);
    check("float_sb_o[8].remote_global_load", 32'(float_sb[8].remote_global_load), 32'd1);
    send(K_AMO, 5'd9, 32'h4000_2000, 12'h000);
    check("int_sb_o[9].remote_global_load", 32'(int_sb[9].remote_global_load), 32'd1);
    send(K_AMO, 5'd10, 32'h9000_0000, 12'h000);
    check("int_sb_o[10].remote_dram_amo", 32'(int_sb[10].remote_dram_amo), 32'd1);
    send(K_FP_LOAD, 5'd11, 32'hc000_0000, 12'h004);
    check("float_sb_o[11].remote_dram_load", 32'(float_sb[11].remote_dram_load), 32'd1);
  endtask

  task automatic test_group();
    // global (5,3), origin (2,1) puts the tile at (3,2)
    write_cfg(2'd0, 6'd5);
    write_cfg(2'd1, 6'd3);
    write_cfg(2'd2, 6'd2);
    write_cfg(2'd3, 6'd1);
    send(K_INT_LOAD, 5'd12, grp(6'd4, 5'd2, 18'h00200), 12'h000);
    check("int_sb_o[12].remote_group_load", 32'(int_sb[12].remote_group_load), 32'd1);
    send(K_INT_LOAD, 5'd13, grp(6'd3, 5'd2, 18'h00400), 12'h000);
    check("int_sb_o[13].remote_dmem_overflow_load",
          32'(int_sb[13].remote_dmem_overflow_load), 32'd1);
    send(K_INT_LOAD, 5'd14, grp(6'd3, 5'd2, 18'h00010), 12'h000);
    check("int_sb_o[14]", 32'(int_sb[14]), 32'd0);
    send(K_AMO, 5'd15, grp(6'd3, 5'd2, 18'h00040), 12'h000);
    check("int_sb_o[15].remote_group_amo", 32'(int_sb[15].remote_group_amo), 32'd1);
    check("int_sb_o[15].remote_group_load", 32'(int_sb[15].remote_group_load), 32'd1);
    send(K_FP_LOAD, 5'd16, grp(6'd1, 5'd0, 18'h00300), 12'h000);
    check("float_sb_o[16].remote_group_load", 32'(float_sb[16].remote_group_load), 32'd1);
  endtask

  task automatic test_gating();
    stall = 1'b1;
    send(K_IDIV, 5'd20, 32'h0, 12'h0);
    check("int_sb_o[20]", 32'(int_sb[20]), 32'd0);
    flush = 1'b1;
    send(K_IDIV, 5'd20, 32'h0, 12'h0);
    check("int_sb_o[20]", 32'(int_sb[20]), 32'd0);
    int_clear = {1'b1, 5'd21};
    send(K_IDIV, 5'd21, 32'h0, 12'h0);
    check("int_sb_o[21].idiv", 32'(int_sb[21].idiv), 32'd1);
  endtask

  task automatic test_random();
    logic [31:0] r, a, c;
    for (int n = 0; n < 300; n++) begin
      rng = xorshift(rng);
      r = rng;
      rng = xorshift(rng);
      a = rng;
      rng = xorshift(rng);
      c = rng;
      // bias toward group space, own tile and global
      case (r[1:0])
        2'd0: a = grp(x_cord_t'(gx - ox), y_cord_t'(gy - oy), a[17:0]);
        2'd1: a = {3'b001, a[28:0]};
        2'd2: a = {2'b01, a[29:0]};
        default: a = a;
      endcase
      issue = {r[7:2], r[12:8], a, r[24:13]};
      issue_v = r[25];
      stall = (r[28:26] == 3'd0);
      flush = (r[31:29] == 3'd0);
      int_clear = {c[1:0] == 2'd0, c[6:2]};
      float_clear = {c[8:7] == 2'd0, c[13:9]};
      cfg = {c[19:15] == 5'd0, c[21:20], c[27:22]};
      tick();
    end
  endtask

  initial begin
    rng = 32'h4edc_314a;
    cycle_count = 0;
    reset = 1'b1;
    issue_v = 1'b0;
    stall = 1'b0;
    flush = 1'b0;
    cfg = '0;
    issue = '0;
    int_clear = '0;
    float_clear = '0;
    gx = '0;
    gy = '0;
    ox = '0;
    oy = '0;
    for (int i = 0; i < `SB_REG_ELS; i++) begin
      ref_int[i] = '0;
      ref_fp[i] = '0;
    end
    repeat (5) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    test_reset();
    test_divides();
    test_dram_global();
    test_group();
    test_gating();
    test_random();
    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

/* scoreboard_top.sv */
`include "scoreboard_defines.svh"

module scoreboard_top (
  input  logic                                          clk_i,
  input  logic                                          reset_i,
  input  manycore_addr_pkg::coord_cfg_s                 cfg_i,
  input  vanilla_pipe_pkg::issue_s                      issue_i,
  input  logic                                          issue_v_i,
  input  logic                                          stall_i,
  input  logic                                          flush_i,
  input  vanilla_pipe_pkg::sb_clear_s                   int_clear_i,
  input  vanilla_pipe_pkg::sb_clear_s                   float_clear_i,
  output vanilla_pipe_pkg::isb_info_s [`SB_REG_ELS-1:0] int_sb_o,
  output vanilla_pipe_pkg::fsb_info_s [`SB_REG_ELS-1:0] float_sb_o
);
  import manycore_addr_pkg::*;
  import vanilla_pipe_pkg::*;

  tile_pos_s     tile_pos;
  remote_class_s issue_class;

  tile_coord_cfg u_coord_cfg (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .cfg_i      (cfg_i),
    .tile_pos_o (tile_pos)
  );

  remote_addr_classifier u_classifier (
    .issue_i    (issue_i),
    .tile_pos_i (tile_pos),
    .class_o    (issue_class)
  );

  scoreboard_tracker u_tracker (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .issue_v_i     (issue_v_i),
    .stall_i       (stall_i),
    .flush_i       (flush_i),
    .rd_i          (issue_i.rd),
    .class_i       (issue_class),
    .int_clear_i   (int_clear_i),
    .float_clear_i (float_clear_i),
    .int_sb_o      (int_sb_o),
    .float_sb_o    (float_sb_o)
  );

endmodule

/* scoreboard_tracker.sv */
`include "scoreboard_defines.svh"

module scoreboard_tracker (
  input  logic                                          clk_i,
  input  logic                                          reset_i,
  input  logic                                          issue_v_i,
  input  logic                                          stall_i,
  input  logic                                          flush_i,
  input  vanilla_pipe_pkg::reg_addr_t                   rd_i,
  input  vanilla_pipe_pkg::remote_class_s               class_i,
  input  vanilla_pipe_pkg::sb_clear_s                   int_clear_i,
  input  vanilla_pipe_pkg::sb_clear_s                   float_clear_i,
  output vanilla_pipe_pkg::isb_info_s [`SB_REG_ELS-1:0] int_sb_o,
  output vanilla_pipe_pkg::fsb_info_s [`SB_REG_ELS-1:0] float_sb_o
);
  import vanilla_pipe_pkg::*;

  isb_info_s [`SB_REG_ELS-1:0] int_sb_r;
  isb_info_s [`SB_REG_ELS-1:0] int_sb_n;
  fsb_info_s [`SB_REG_ELS-1:0] float_sb_r;
  fsb_info_s [`SB_REG_ELS-1:0] float_sb_n;
  logic                        issue_fire;

  // issue only counts when decode actually advances
  assign issue_fire = issue_v_i & ~stall_i & ~flush_i;

  always_comb begin
    int_sb_n   = int_sb_r;
    float_sb_n = float_sb_r;
    for (int i = 0; i < `SB_REG_ELS; i++) begin
      // clear drops the whole entry
      if (int_clear_i.v && (int_clear_i.id == reg_addr_t'(i))) begin
        int_sb_n[i] = '0;
      end
      if (float_clear_i.v && (float_clear_i.id == reg_addr_t'(i))) begin
        float_sb_n[i] = '0;
      end
      // set applied last so it beats a same-cycle clear
      if (issue_fire && (rd_i == reg_addr_t'(i))) begin
        int_sb_n[i]   = int_sb_n[i] | class_i.isb;
        float_sb_n[i] = float_sb_n[i] | class_i.fsb;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      int_sb_r   <= '0;
      float_sb_r <= '0;
    end else begin
      int_sb_r   <= int_sb_n;
      float_sb_r <= float_sb_n;
    end
  end

  assign int_sb_o   = int_sb_r;
  assign float_sb_o = float_sb_r;

endmodule

/* tile_coord_cfg.sv */
`include "scoreboard_defines.svh"

module tile_coord_cfg (
  input  logic                         clk_i,
  input  logic                         reset_i,
  input  manycore_addr_pkg::coord_cfg_s cfg_i,
  output manycore_addr_pkg::tile_pos_s  tile_pos_o
);
  import manycore_addr_pkg::*;

  x_cord_t global_x_r;
  y_cord_t global_y_r;
  x_cord_t origin_x_r;
  y_cord_t origin_y_r;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      global_x_r <= '0;
      global_y_r <= '0;
      origin_x_r <= '0;
      origin_y_r <= '0;
    end else if (cfg_i.v) begin
      case (cfg_i.sel)
        CFG_SEL_GLOBAL_X: global_x_r <= cfg_i.value;
        CFG_SEL_GLOBAL_Y: global_y_r <= cfg_i.value[`SB_Y_CORD_WIDTH-1:0];
        CFG_SEL_ORIGIN_X: origin_x_r <= cfg_i.value;
        default:          origin_y_r <= cfg_i.value[`SB_Y_CORD_WIDTH-1:0];
      endcase
    end
  end

  // relative position wraps at the field width
  assign tile_pos_o.x = global_x_r - origin_x_r;
  assign tile_pos_o.y = global_y_r - origin_y_r;

endmodule

/* vanilla_pipe_pkg.sv */
`include "scoreboard_defines.svh"

package vanilla_pipe_pkg;

  typedef logic [`SB_DATA_WIDTH-1:0] data_t;
  typedef logic [`SB_REG_ADDR_WIDTH-1:0] reg_addr_t;
  typedef logic [`SB_IMM_WIDTH-1:0] imm_t;

  // decoded instruction sitting in decode
  typedef struct packed {
    logic      is_load;
    logic      is_amo;
    logic      is_idiv;
    logic      is_fdiv_fsqrt;
    logic      write_rd;
    logic      write_frd;
    reg_addr_t rd;
    data_t     rs1_val;
    imm_t      imm;
  } issue_s;

  typedef struct packed {
    logic      v;
    reg_addr_t id;
  } sb_clear_s;

  // integer scoreboard entry
  typedef struct packed {
    logic idiv;
    logic remote_dram_load;
    logic remote_dram_amo;
    logic remote_dmem_overflow_load;
    logic remote_global_load;
    logic remote_group_load;
    logic remote_group_amo;
  } isb_info_s;

  // float scoreboard entry
  typedef struct packed {
    logic fdiv_fsqrt;
    logic remote_dram_load;
    logic remote_global_load;
    logic remote_group_load;
    logic remote_dmem_overflow_load;
  } fsb_info_s;

  // bits an issue would set, laid out like the entries
  typedef struct packed {
    isb_info_s isb;
    fsb_info_s fsb;
  } remote_class_s;

endpackage
